// ==== src/br_pkg.sv ====
package br_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int xlen     = 32;
    localparam int rob_id_w = 5;

    // sequential pc offset, also the link value offset
    localparam logic [xlen-1:0] pc_step = 32'd4;

    //////////////////////////////
    // opcodes
    //////////////////////////////

    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5,
        BR_JAL  = 3'd6,
        BR_JALR = 3'd7
    } br_op_t;

    //////////////////////////////
    // payloads
    //////////////////////////////

    // one branch uop from dispatch, operands already read
    typedef struct packed {
        logic [rob_id_w-1:0] rob_id;
        br_op_t              fu_opcode;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     rs1_value;
        logic [xlen-1:0]     rs2_value;
        logic [xlen-1:0]     imm;
        logic                predict_taken;
        logic [xlen-1:0]     predict_target;
    } br_uop_t;

    // resolved branch toward the rob
    typedef struct packed {
        logic [rob_id_w-1:0] rob_id;
        logic [xlen-1:0]     rd_value;
        logic                taken;
        logic [xlen-1:0]     target;
        logic                miss_predict;
    } br_result_t;

    // frontend redirect
    typedef struct packed {
        logic                valid;
        logic [rob_id_w-1:0] rob_id;
        logic [xlen-1:0]     target;
    } br_redirect_t;

endpackage

// ==== src/br_credit_fifo.sv ====
`timescale 1ns/1ps

module br_credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,

    input  logic     enq_valid,
    input  payload_t enq_data,

    input  logic     deq,
    output logic     deq_valid,
    output payload_t deq_data,

    output logic     credit
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;

    logic               full;
    logic               empty;
    logic               push;
    logic               pop;

    assign full  = (count == cnt_w'(depth));
    assign empty = (count == '0);
    assign push  = enq_valid;
    assign pop   = deq && !empty;

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // head is visible the cycle after the write
    assign deq_valid = !empty;
    assign deq_data  = mem[rd_ptr];

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
        end else if (push) begin
            if (wr_ptr == ptr_w'(depth - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + ptr_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
        end else if (pop) begin
            if (rd_ptr == ptr_w'(depth - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + ptr_w'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + cnt_w'(1);
                2'b01:   count <= count - cnt_w'(1);
                default: count <= count;
            endcase
        end
    end

    // one credit back upstream per pop, none for flushed entries
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            credit <= 1'b0;
        end else begin
            credit <= pop;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // upstream overran its credits
    a_no_enq_full: assert property (
        @(posedge clk) disable iff (rst)
        (enq_valid && !flush) |-> !full
    );

    a_no_deq_empty: assert property (
        @(posedge clk) disable iff (rst)
        deq |-> !empty
    );

endmodule

// ==== src/br_resolve.sv ====
`timescale 1ns/1ps

module br_resolve
import br_pkg::*;
#(
    parameter int res_depth = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,

    input  logic       in_valid,
    input  br_uop_t    in_uop,
    output logic       pop,

    input  logic       res_credit,
    output logic       out_valid,
    output br_result_t out_res
);

    localparam int cnt_w = $clog2(res_depth + 1);

    logic [cnt_w-1:0] credit_cnt;

    logic             s1_valid;
    br_uop_t          s1_uop;

    logic             s2_valid;
    br_result_t       s2_res;

    //////////////////////////////
    // credits toward result fifo
    //////////////////////////////

    // a credit is taken when the uop enters stage 1
    assign pop = in_valid && (credit_cnt != '0) && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            credit_cnt <= cnt_w'(res_depth);
        end else begin
            credit_cnt <= credit_cnt - cnt_w'(pop) + cnt_w'(res_credit);
        end
    end

    //////////////////////////////
    // stage 1
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            s1_uop <= in_uop;
        end
    end

    //////////////////////////////
    // resolve
    //////////////////////////////

    logic            taken;
    logic [xlen-1:0] target;
    logic [xlen-1:0] jump_target;
    logic [xlen-1:0] seq_pc;
    logic            miss_predict;

    always_comb begin
        case (s1_uop.fu_opcode)
            BR_BEQ:  taken = (s1_uop.rs1_value == s1_uop.rs2_value);
            BR_BNE:  taken = (s1_uop.rs1_value != s1_uop.rs2_value);
            BR_BLT:  taken = ($signed(s1_uop.rs1_value) <  $signed(s1_uop.rs2_value));
            BR_BGE:  taken = ($signed(s1_uop.rs1_value) >= $signed(s1_uop.rs2_value));
            BR_BLTU: taken = (s1_uop.rs1_value <  s1_uop.rs2_value);
            BR_BGEU: taken = (s1_uop.rs1_value >= s1_uop.rs2_value);
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr is register relative with bit 0 cleared
    always_comb begin
        if (s1_uop.fu_opcode == BR_JALR) begin
            jump_target = (s1_uop.rs1_value + s1_uop.imm) & ~(xlen'(1));
        end else begin
            jump_target = s1_uop.pc + s1_uop.imm;
        end
    end

    assign seq_pc = s1_uop.pc + pc_step;
    assign target = taken ? jump_target : seq_pc;

    assign miss_predict = (taken != s1_uop.predict_taken) ||
                          (target != s1_uop.predict_target);

    //////////////////////////////
    // stage 2
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_res.rob_id       <= s1_uop.rob_id;
            s2_res.rd_value     <= seq_pc;
            s2_res.taken        <= taken;
            s2_res.target       <= target;
            s2_res.miss_predict <= miss_predict;
        end
    end

    assign out_valid = s2_valid;
    assign out_res   = s2_res;

    //////////////////////////////
    // checks
    //////////////////////////////

    // more credits back than were handed out
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credit_cnt <= cnt_w'(res_depth)
    );

    a_opcode_known: assert property (
        @(posedge clk) disable iff (rst)
        s1_valid |-> !$isunknown(s1_uop.fu_opcode)
    );

endmodule

// ==== src/br_retire_port.sv ====
`timescale 1ns/1ps

module br_retire_port
import br_pkg::*;
#(
    parameter int res_depth   = 4,
    parameter int rob_credits = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,

    input  logic         enq_valid,
    input  br_result_t   enq_res,
    output logic         res_credit,

    input  logic         rob_credit,
    output logic         res_valid,
    output br_result_t   res,

    output br_redirect_t redirect,

    output logic [31:0]  perf_br_cnt,
    output logic [31:0]  perf_mispredict_cnt
);

    localparam int rob_cnt_w = $clog2(rob_credits + 1);

    logic                 head_valid;
    br_result_t           head_res;
    logic                 send;
    logic [rob_cnt_w-1:0] rob_cnt;

    //////////////////////////////
    // result queue
    //////////////////////////////

    br_credit_fifo #(
        .payload_t (br_result_t),
        .depth     (res_depth)
    ) u_res_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .enq_valid (enq_valid),
        .enq_data  (enq_res),
        .deq       (send),
        .deq_valid (head_valid),
        .deq_data  (head_res),
        .credit    (res_credit)
    );

    //////////////////////////////
    // send to rob
    //////////////////////////////

    // nothing leaves during a flush
    assign send      = head_valid && (rob_cnt != '0) && !flush;
    assign res_valid = send;
    assign res       = head_res;

    // sent results stay sent, so flush keeps these credits
    always_ff @(posedge clk) begin
        if (rst) begin
            rob_cnt <= rob_cnt_w'(rob_credits);
        end else begin
            rob_cnt <= rob_cnt - rob_cnt_w'(send) + rob_cnt_w'(rob_credit);
        end
    end

    always_comb begin
        redirect.valid  = send && head_res.miss_predict;
        redirect.rob_id = head_res.rob_id;
        redirect.target = head_res.target;
    end

    //////////////////////////////
    // perf counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            perf_br_cnt         <= '0;
            perf_mispredict_cnt <= '0;
        end else if (send) begin
            perf_br_cnt         <= perf_br_cnt + 32'd1;
            perf_mispredict_cnt <= perf_mispredict_cnt + {31'd0, head_res.miss_predict};
        end
    end

    // rob returned a credit it never got
    a_rob_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        rob_cnt <= rob_cnt_w'(rob_credits)
    );

endmodule

// ==== src/br_unit_top.sv ====
`timescale 1ns/1ps

module br_unit_top
import br_pkg::*;
#(
    parameter int uop_depth   = 4,
    parameter int res_depth   = 4,
    parameter int rob_credits = 2
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         backend_flush,

    input  logic         uop_valid,
    input  br_uop_t      uop,
    output logic         uop_credit,

    input  logic         rob_credit,
    output logic         res_valid,
    output br_result_t   res,

    output br_redirect_t redirect,

    output logic [31:0]  perf_br_cnt,
    output logic [31:0]  perf_mispredict_cnt
);

    logic       head_valid;
    br_uop_t    head_uop;
    logic       pop;
    logic       rs_valid;
    br_result_t rs_res;
    logic       res_credit;

    br_credit_fifo #(
        .payload_t (br_uop_t),
        .depth     (uop_depth)
    ) u_uop_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (backend_flush),
        .enq_valid (uop_valid),
        .enq_data  (uop),
        .deq       (pop),
        .deq_valid (head_valid),
        .deq_data  (head_uop),
        .credit    (uop_credit)
    );

    br_resolve #(
        .res_depth (res_depth)
    ) u_resolve (
        .clk        (clk),
        .rst        (rst),
        .flush      (backend_flush),
        .in_valid   (head_valid),
        .in_uop     (head_uop),
        .pop        (pop),
        .res_credit (res_credit),
        .out_valid  (rs_valid),
        .out_res    (rs_res)
    );

    br_retire_port #(
        .res_depth   (res_depth),
        .rob_credits (rob_credits)
    ) u_retire (
        .clk                 (clk),
        .rst                 (rst),
        .flush               (backend_flush),
        .enq_valid           (rs_valid),
        .enq_res             (rs_res),
        .res_credit          (res_credit),
        .rob_credit          (rob_credit),
        .res_valid           (res_valid),
        .res                 (res),
        .redirect            (redirect),
        .perf_br_cnt         (perf_br_cnt),
        .perf_mispredict_cnt (perf_mispredict_cnt)
    );

endmodule

// ==== test/br_unit_ref.svh ====
//////////////////////////////
// branch reference model
//////////////////////////////

// expected resolve of one uop, straight from the branch rules
function automatic br_result_t expected_result(input br_uop_t u);
    br_result_t             r;
    logic signed [xlen-1:0] a;
    logic signed [xlen-1:0] b;
    logic                   tk;
    logic [xlen-1:0]        dest;
    a = u.rs1_value;
    b = u.rs2_value;
    case (u.fu_opcode)
        BR_BEQ:  tk = (u.rs1_value == u.rs2_value);
        BR_BNE:  tk = !(u.rs1_value == u.rs2_value);
        BR_BLT:  tk = (a < b);
        BR_BGE:  tk = !(a < b);
        BR_BLTU: tk = (u.rs1_value < u.rs2_value);
        BR_BGEU: tk = !(u.rs1_value < u.rs2_value);
        BR_JAL:  tk = 1'b1;
        BR_JALR: tk = 1'b1;
        default: tk = 1'b0;
    endcase
    if (!tk) begin
        dest = u.pc + 32'd4;
    end else if (u.fu_opcode == BR_JALR) begin
        dest    = u.rs1_value + u.imm;
        dest[0] = 1'b0;
    end else begin
        dest = u.pc + u.imm;
    end
    r.rob_id       = u.rob_id;
    r.rd_value     = u.pc + 32'd4;
    r.taken        = tk;
    r.target       = dest;
    // wrong direction or wrong target
    r.miss_predict = (tk != u.predict_taken) || (dest != u.predict_target);
    return r;
endfunction

// redirect seen together with a result
function automatic br_redirect_t expected_redirect(input br_result_t r);
    br_redirect_t d;
    d.valid  = r.miss_predict;
    d.rob_id = r.rob_id;
    d.target = r.target;
    return d;
endfunction

// ==== test/br_unit_tb.sv ====
`timescale 1ns/1ps

module br_unit_tb
import br_pkg::*;
();

    localparam int uop_depth   = 4;
    localparam int res_depth   = 4;
    localparam int rob_credits = 2;
    localparam int num_uops    = 400;
    localparam int flush_gap   = 150;
    localparam int half_period = 5;

    logic         clk;
    logic         rst;
    logic         backend_flush;
    logic         uop_valid;
    br_uop_t      uop;
    logic         uop_credit;
    logic         rob_credit;
    logic         res_valid;
    br_result_t   res;
    br_redirect_t redirect;
    logic [31:0]  perf_br_cnt;
    logic [31:0]  perf_mispredict_cnt;

    br_result_t   exp_q [$];
    int           rob_owed = 0;
    int           rcv_cnt  = 0;
    int           miss_cnt = 0;
    logic [15:0]  lfsr_state = 16'd22779;
    logic         credit_seen = 1'b0;

    `include "br_unit_ref.svh"

    br_unit_top #(
        .uop_depth   (uop_depth),
        .res_depth   (res_depth),
        .rob_credits (rob_credits)
    ) DUT (
        .clk                 (clk),
        .rst                 (rst),
        .backend_flush       (backend_flush),
        .uop_valid           (uop_valid),
        .uop                 (uop),
        .uop_credit          (uop_credit),
        .rob_credit          (rob_credit),
        .res_valid           (res_valid),
        .res                 (res),
        .redirect            (redirect),
        .perf_br_cnt         (perf_br_cnt),
        .perf_mispredict_cnt (perf_mispredict_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            abort_run("value mismatch between DUT and reference");
        end
    endtask

    // galois lfsr for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return {1'b0, s[15:1]} ^ 16'hB400;
        end
        return {1'b0, s[15:1]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] boundary_value();
        case (2'(rand_bits(2)))
            2'd0:    return 32'h8000_0000;
            2'd1:    return 32'h7fff_ffff;
            2'd2:    return 32'h0000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic br_uop_t random_uop(input int seq);
        br_uop_t     u;
        br_result_t  r;
        logic [2:0]  op;
        logic [12:0] off;
        logic [1:0]  mode;
        op          = 3'(rand_bits(3));
        u.rob_id    = rob_id_w'(seq);
        u.fu_opcode = br_op_t'(op);
        u.pc        = rand_bits(32) & ~32'h3;
        mode        = 2'(rand_bits(2));
        u.rs1_value = rand_bits(32);
        if (mode == 2'd0) begin
            u.rs2_value = u.rs1_value;
        end else if (mode == 2'd1) begin
            u.rs1_value = boundary_value();
            u.rs2_value = boundary_value();
        end else begin
            u.rs2_value = rand_bits(32);
        end
        off   = 13'(rand_bits(13));
        u.imm = {{19{off[12]}}, off};
        // prediction is built around the real outcome
        u.predict_taken  = 1'b0;
        u.predict_target = '0;
        r    = expected_result(u);
        mode = 2'(rand_bits(2));
        if (mode == 2'd2) begin
            u.predict_taken  = !r.taken;
            u.predict_target = r.target;
        end else if (mode == 2'd3) begin
            u.predict_taken  = r.taken;
            u.predict_target = r.target ^ (rand_bits(32) | 32'h4);
        end else begin
            u.predict_taken  = r.taken;
            u.predict_target = r.target;
        end
        return u;
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // dispatch credit pulse as seen in the middle of the cycle
    always @(negedge clk) begin
        credit_seen = uop_credit;
    end

    initial begin : stimulus
        int      credits;
        int      sent;
        int      rob_hold;
        int      next_flush;
        logic    flushing;
        br_uop_t u;
        rst           = 1'b1;
        backend_flush = 1'b0;
        uop_valid     = 1'b0;
        uop           = '0;
        rob_credit    = 1'b0;
        credits       = uop_depth;
        sent          = 0;
        rob_hold      = 0;
        next_flush    = flush_gap;
        flushing      = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (sent < num_uops || exp_q.size() != 0) begin
            @(posedge clk);
            // rob side holds back credits for long stretches
            if (rob_hold > 0) begin
                rob_hold--;
                rob_credit <= 1'b0;
            end else if (rand_bits(4) == 0) begin
                rob_hold = 16 + int'(rand_bits(4));
                rob_credit <= 1'b0;
            end else if (rob_owed > 0 && rand_bits(1) == 1) begin
                rob_owed--;
                rob_credit <= 1'b1;
            end else begin
                rob_credit <= 1'b0;
            end
            // dispatch credits
            if (flushing) begin
                backend_flush <= 1'b0;
                flushing = 1'b0;
                credits  = uop_depth;
            end else if (credit_seen) begin
                credits++;
            end
            if (credits > uop_depth) begin
                abort_run("dispatch got back more credits than it spent");
            end
            if (sent == next_flush) begin
                backend_flush <= 1'b1;
                uop_valid     <= 1'b0;
                flushing   = 1'b1;
                next_flush = next_flush + flush_gap;
                exp_q.delete();
            end else if (sent < num_uops && credits > 0 && rand_bits(2) != 0) begin
                u = random_uop(sent);
                uop       <= u;
                uop_valid <= 1'b1;
                credits--;
                sent++;
                exp_q.push_back(expected_result(u));
            end else begin
                uop_valid <= 1'b0;
            end
        end
        @(posedge clk);
        uop_valid  <= 1'b0;
        rob_credit <= 1'b0;
        repeat (3) @(posedge clk);
        check_equal("perf_br_cnt", perf_br_cnt, 32'(rcv_cnt));
        check_equal("perf_mispredict_cnt", perf_mispredict_cnt, 32'(miss_cnt));
        $display("Finished with no errors");
        $finish;
    end

    //////////////////////////////
    // scoreboard
    //////////////////////////////

    always @(negedge clk) begin : compare
        br_result_t   exp_res;
        br_redirect_t exp_redir;
        if (!rst) begin
            if (res_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("DUT sent a result with no uop outstanding");
                end
                exp_res   = exp_q.pop_front();
                exp_redir = expected_redirect(exp_res);
                check_equal("res.rob_id", 32'(res.rob_id), 32'(exp_res.rob_id));
                check_equal("res.rd_value", res.rd_value, exp_res.rd_value);
                check_equal("res.taken", 32'(res.taken), 32'(exp_res.taken));
                check_equal("res.target", res.target, exp_res.target);
                check_equal("res.miss_predict", 32'(res.miss_predict),
                            32'(exp_res.miss_predict));
                check_equal("redirect.valid", 32'(redirect.valid), 32'(exp_redir.valid));
                if (exp_redir.valid) begin
                    check_equal("redirect.rob_id", 32'(redirect.rob_id),
                                32'(exp_redir.rob_id));
                    check_equal("redirect.target", redirect.target, exp_redir.target);
                end
                rcv_cnt++;
                if (exp_res.miss_predict) begin
                    miss_cnt++;
                end
                rob_owed++;
            end else begin
                check_equal("redirect.valid", 32'(redirect.valid), 32'd0);
            end
        end
    end

    initial begin : watchdog
        repeat (num_uops * 40) @(posedge clk);
        abort_run("timeout, the run took longer than the watchdog allows");
    end

endmodule

// ==== br_unit.f ====
+incdir+test
src/br_pkg.sv
src/br_credit_fifo.sv
src/br_resolve.sv
src/br_retire_port.sv
src/br_unit_top.sv
test/br_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the branch unit testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
    --top-module br_unit_tb -f br_unit.f -o br_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/br_unit_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Finished with errors" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation passed"
exit 0
